// ==== hyperbus_bridge.f ====
hw/hbus_cfg_pkg.sv
hw/hbus_cmd_pkg.sv
hw/hbus_native_if.sv
hw/async_fifo.sv
hw/hyperbus_fifo.sv
hw/hbus_phy.sv
hw/hyperbus_bridge.sv
tb/hyperram_model.sv
tb/tb_hyperbus_bridge.sv

// ==== Bender.yml ====
package:
  name: hyperbus_bridge

sources:
  - files:
      - hw/hbus_cfg_pkg.sv
      - hw/hbus_cmd_pkg.sv
      - hw/hbus_native_if.sv
      - hw/async_fifo.sv
      - hw/hyperbus_fifo.sv
      - hw/hbus_phy.sv
      - hw/hyperbus_bridge.sv
  - target: test
    files:
      - tb/hyperram_model.sv
      - tb/tb_hyperbus_bridge.sv

// ==== tb/tb_hyperbus_bridge.sv ====
/*
  Testbench for the HyperBus memory bridge
  Directed tests through the user ports against a HyperRAM model
*/

`timescale 1ns/1ns

module tb_hyperbus_bridge;

  import hbus_cfg_pkg::*;
  import hbus_cmd_pkg::*;

  localparam int FIFO_DATA_WIDTH = 32;
  localparam int FIFO_ASIZE      = 2;
  localparam int LATENCY         = 6;
  localparam int STREAM_LEN      = 10;
  localparam int WAIT_LIMIT      = 1000;

  logic                       clk;
  logic                       hbus_clk;
  logic                       hbus_rst;
  logic                       rrq_i;
  logic                       wrq_i;
  logic [HBUS_ADDR_WIDTH-1:0] adr_i;
  logic [FIFO_DATA_WIDTH-1:0] tx_dat_i;
  logic                       cmd_ready_o;
  logic [FIFO_DATA_WIDTH-1:0] rx_dat_o;
  logic                       rx_valid_o;
  logic                       cs_n_o;
  logic                       ck_o;
  logic [HBUS_DQ_WIDTH-1:0]   dq_o;
  logic                       dq_oe_o;
  logic                       rwds_o;
  logic [HBUS_DQ_WIDTH-1:0]   dq_i;
  logic                       rwds_i;

  hbus_cmd_t model_cmd;
  logic      model_ca_ok;
  int        model_txn_cnt;

  // Results in arrival order and the expected memory contents
  logic [FIFO_DATA_WIDTH-1:0] rx_q [$];
  logic [HBUS_DATA_WIDTH-1:0] ref_mem [logic [HBUS_ADDR_WIDTH-1:0]];
  int                         errors;
  logic                       ready_dropped;

  // Requests in issue order, matched against each decoded command-address
  hbus_cmd_t                  cmd_q [$];
  int                         cmd_seen;

  hyperbus_bridge #(
    .FIFO_DATA_WIDTH (FIFO_DATA_WIDTH),
    .FIFO_ASIZE      (FIFO_ASIZE),
    .LATENCY         (LATENCY)
  ) u_dut (
    .clk         (clk),
    .hbus_clk    (hbus_clk),
    .hbus_rst    (hbus_rst),
    .rrq_i       (rrq_i),
    .wrq_i       (wrq_i),
    .adr_i       (adr_i),
    .tx_dat_i    (tx_dat_i),
    .cmd_ready_o (cmd_ready_o),
    .rx_dat_o    (rx_dat_o),
    .rx_valid_o  (rx_valid_o),
    .cs_n_o      (cs_n_o),
    .ck_o        (ck_o),
    .dq_o        (dq_o),
    .dq_oe_o     (dq_oe_o),
    .rwds_o      (rwds_o),
    .dq_i        (dq_i),
    .rwds_i      (rwds_i)
  );

  hyperram_model #(
    .LATENCY     (LATENCY),
    .BURST_WORDS (FIFO_DATA_WIDTH / HBUS_DATA_WIDTH)
  ) u_model (
    .hbus_clk   (hbus_clk),
    .cs_n_i     (cs_n_o),
    .dq_i       (dq_o),
    .dq_oe_i    (dq_oe_o),
    .dq_o       (dq_i),
    .rwds_o     (rwds_i),
    .last_cmd_o (model_cmd),
    .ca_ok_o    (model_ca_ok),
    .txn_cnt_o  (model_txn_cnt)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    hbus_clk = 1'b0;
    #7;
    forever #10 hbus_clk = ~hbus_clk;
  end

  // rx_valid_o moves on the rising edge, so count pulses on the falling one
  always @(negedge clk) begin
    if (rx_valid_o === 1'b1) begin
      rx_q.push_back(rx_dat_o);
    end
  end

  task automatic fail_run(input string what);
    errors++;
    $display("%s", what);
    $display("Checks failed");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_run($sformatf("CHECK FAILED at %0t ns: %s got %b expected %b",
                         $time, name, got, exp));
    end
  endtask

  task automatic check_data(input string name, input logic [FIFO_DATA_WIDTH-1:0] got,
                            input logic [FIFO_DATA_WIDTH-1:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("CHECK FAILED at %0t ns: %s got %h expected %h",
                         $time, name, got, exp));
    end
  endtask

  task automatic check_cmd(input string name, input hbus_cmd_t got, input hbus_cmd_t exp);
    if (got !== exp) begin
      fail_run($sformatf("CHECK FAILED at %0t ns: %s got op %0d adr %h expected op %0d adr %h",
                         $time, name, got.op, got.adr, exp.op, exp.adr));
    end
  endtask

  // Every transaction the model decodes must match the oldest request
  always @(posedge clk) begin
    #2;
    if (model_txn_cnt > cmd_seen) begin
      cmd_seen++;
      if (cmd_q.size() == 0) begin
        fail_run("A bus transaction appeared with no request outstanding");
      end else begin
        check_cmd("command-address", model_cmd, cmd_q.pop_front());
        check_bit("command-address burst and reserved bits", model_ca_ok, 1'b1);
      end
    end
  end

  function automatic hbus_cmd_t make_cmd(input hbus_op_e op,
                                         input logic [HBUS_ADDR_WIDTH-1:0] adr);
    hbus_cmd_t cmd;
    cmd.op  = op;
    cmd.adr = adr;
    return cmd;
  endfunction

  // Stored word, or the fill value of a word never written
  function automatic logic [HBUS_DATA_WIDTH-1:0] mem_word(
    input logic [HBUS_ADDR_WIDTH-1:0] adr
  );
    if (ref_mem.exists(adr)) begin
      return ref_mem[adr];
    end
    return adr[15:0] ^ 16'hA5A5;
  endfunction

  function automatic logic [FIFO_DATA_WIDTH-1:0] expected_read(
    input logic [HBUS_ADDR_WIDTH-1:0] adr
  );
    return {mem_word(adr), mem_word(adr + 1)};
  endfunction

  task automatic wait_cmd_ready();
    int cycles;
    cycles = 0;
    while (cmd_ready_o !== 1'b1) begin
      if (cycles == WAIT_LIMIT) begin
        fail_run("Timed out waiting for cmd_ready_o to rise");
      end
      ready_dropped = 1'b1;
      @(posedge clk);
      #2;
      cycles++;
    end
  endtask

  task automatic wait_results(input int count);
    int cycles;
    cycles = 0;
    while (rx_q.size() < count) begin
      if (cycles == WAIT_LIMIT) begin
        fail_run("Timed out waiting for read results on rx_valid_o");
      end
      @(posedge clk);
      #2;
      cycles++;
    end
  endtask

  // Until the model has seen the transaction and chip select is back high
  task automatic wait_bus_done(input int target);
    int cycles;
    cycles = 0;
    while (model_txn_cnt < target || cs_n_o !== 1'b1) begin
      if (cycles == WAIT_LIMIT) begin
        fail_run("Timed out waiting for the bus transaction to finish");
      end
      @(posedge clk);
      #2;
      cycles++;
    end
  endtask

  // Drives a one-cycle request strobe 2 ns after a rising clk edge
  task automatic send_request(input hbus_op_e op, input logic [HBUS_ADDR_WIDTH-1:0] adr,
                              input logic [FIFO_DATA_WIDTH-1:0] data);
    wait_cmd_ready();
    adr_i    = adr;
    tx_dat_i = data;
    rrq_i    = (op == HBUS_OP_READ);
    wrq_i    = (op == HBUS_OP_WRITE);
    cmd_q.push_back(make_cmd(op, adr));
    if (op == HBUS_OP_WRITE) begin
      ref_mem[adr]     = data[31:16];
      ref_mem[adr + 1] = data[15:0];
    end
    @(posedge clk);
    #2;
    rrq_i = 1'b0;
    wrq_i = 1'b0;
  endtask

  task automatic check_last_cmd(input hbus_op_e op, input logic [HBUS_ADDR_WIDTH-1:0] adr);
    check_cmd("command-address", model_cmd, make_cmd(op, adr));
    check_bit("command-address burst and reserved bits", model_ca_ok, 1'b1);
  endtask

  task automatic test_reset();
    int i;
    #2;
    hbus_rst = 1'b1;
    for (i = 0; i < 16; i++) begin
      @(posedge clk);
      #2;
      check_bit("cs_n_o", cs_n_o, 1'b1);
      check_bit("ck_o", ck_o, 1'b0);
      check_bit("dq_oe_o", dq_oe_o, 1'b0);
      check_bit("rwds_o", rwds_o, 1'b0);
      check_bit("rx_valid_o", rx_valid_o, 1'b0);
    end
    hbus_rst = 1'b0;
    @(posedge clk);
    #2;
    check_bit("cs_n_o", cs_n_o, 1'b1);
    check_bit("dq_oe_o", dq_oe_o, 1'b0);
    check_bit("rx_valid_o", rx_valid_o, 1'b0);
    wait_cmd_ready();
  endtask

  task automatic test_write_read(input logic [HBUS_ADDR_WIDTH-1:0] adr,
                                 input logic [FIFO_DATA_WIDTH-1:0] data);
    int                         start;
    logic [FIFO_DATA_WIDTH-1:0] got;
    start = model_txn_cnt;
    send_request(HBUS_OP_WRITE, adr, data);
    wait_bus_done(start + 1);
    check_last_cmd(HBUS_OP_WRITE, adr);
    send_request(HBUS_OP_READ, adr, '0);
    wait_results(1);
    wait_bus_done(start + 2);
    check_last_cmd(HBUS_OP_READ, adr);
    got = rx_q.pop_front();
    check_data("rx_dat_o", got, data);
  endtask

  task automatic test_unwritten(input logic [HBUS_ADDR_WIDTH-1:0] adr);
    int                         start;
    logic [FIFO_DATA_WIDTH-1:0] got;
    start = model_txn_cnt;
    send_request(HBUS_OP_READ, adr, '0);
    wait_results(1);
    wait_bus_done(start + 1);
    check_last_cmd(HBUS_OP_READ, adr);
    got = rx_q.pop_front();
    check_data("rx_dat_o", got, {adr[15:0] ^ 16'hA5A5, (adr[15:0] + 16'd1) ^ 16'hA5A5});
  endtask

  // Back-to-back writes past the FIFO depth, then reads of the same words
  task automatic test_stream();
    logic [HBUS_ADDR_WIDTH-1:0] adrs [STREAM_LEN];
    logic [FIFO_DATA_WIDTH-1:0] got;
    int                         i;
    ready_dropped = 1'b0;
    for (i = 0; i < STREAM_LEN; i++) begin
      adrs[i] = $urandom() & 32'hFFFF_FFFE;
      send_request(HBUS_OP_WRITE, adrs[i], $urandom());
    end
    if (!ready_dropped) begin
      fail_run("cmd_ready_o never dropped while the write stream was issued");
    end
    for (i = 0; i < STREAM_LEN; i++) begin
      send_request(HBUS_OP_READ, adrs[i], '0);
    end
    wait_results(STREAM_LEN);
    for (i = 0; i < STREAM_LEN; i++) begin
      got = rx_q.pop_front();
      check_data($sformatf("rx_dat_o result %0d", i), got, expected_read(adrs[i]));
    end
  endtask

  // No result may show up during a quiet period without a read
  task automatic check_no_extra_results();
    int i;
    for (i = 0; i < 100; i++) begin
      @(posedge clk);
      #2;
    end
    if (rx_q.size() != 0) begin
      fail_run("rx_valid_o pulsed more often than reads were issued");
    end
    if (cmd_q.size() != 0) begin
      fail_run("Some requests never appeared as bus transactions");
    end
  endtask

  initial begin
    errors        = 0;
    cmd_seen      = 0;
    ready_dropped = 1'b0;
    void'($urandom(29));
    hbus_rst = 1'b0;
    rrq_i    = 1'b0;
    wrq_i    = 1'b0;
    adr_i    = '0;
    tx_dat_i = '0;
    test_reset();
    test_write_read(32'h0000_1234, 32'hDEAD_BEEF);
    test_write_read(32'hF0E1_D2C6, 32'h0123_4567);
    test_unwritten(32'h5A5A_0F00);
    test_stream();
    check_no_extra_results();
    if (errors == 0) begin
      $display("All checks passed");
      $finish;
    end else begin
      $display("Checks failed");
      $fatal(1, "Run ended with errors");
    end
  end

endmodule

// ==== tb/hyperram_model.sv ====
/*
  Behavioral HyperRAM device model
  Decodes the command-address, waits the fixed latency, then stores
  write bytes or returns read bytes with the strobe high
*/

`timescale 1ns/1ns

module hyperram_model #(
  parameter int LATENCY     = 6,
  parameter int BURST_WORDS = 2
) (
  input  logic                                   hbus_clk,
  input  logic                                   cs_n_i,
  input  logic [hbus_cfg_pkg::HBUS_DQ_WIDTH-1:0] dq_i,
  input  logic                                   dq_oe_i,
  output logic [hbus_cfg_pkg::HBUS_DQ_WIDTH-1:0] dq_o,
  output logic                                   rwds_o,
  output hbus_cmd_pkg::hbus_cmd_t                last_cmd_o,
  output logic                                   ca_ok_o,
  output int                                     txn_cnt_o
);

  import hbus_cfg_pkg::*;
  import hbus_cmd_pkg::*;

  // Sparse word memory, unwritten words follow the fill rule
  logic [HBUS_DATA_WIDTH-1:0] mem [logic [HBUS_ADDR_WIDTH-1:0]];

  logic [CA_WIDTH-1:0]        ca;
  logic [HBUS_DATA_WIDTH-1:0] rd_word;
  logic [HBUS_DQ_WIDTH-1:0]   wr_hi;
  hbus_cmd_t                  cur_cmd;
  int                         ca_cnt;
  int                         lat_cnt;
  int                         byte_cnt;

  function automatic logic [HBUS_DATA_WIDTH-1:0] read_word(
    input logic [HBUS_ADDR_WIDTH-1:0] adr
  );
    if (mem.exists(adr)) begin
      return mem[adr];
    end
    return adr[15:0] ^ 16'hA5A5;
  endfunction

  initial begin
    dq_o       = '0;
    rwds_o     = 1'b0;
    last_cmd_o = '0;
    ca_ok_o    = 1'b0;
    txn_cnt_o  = 0;
    ca_cnt     = 0;
    lat_cnt    = 0;
    byte_cnt   = 0;
  end

  // Pins change on the rising bus clock, so sample and drive on the falling one
  always @(negedge hbus_clk) begin
    if (cs_n_i !== 1'b0) begin
      ca_cnt   = 0;
      lat_cnt  = 0;
      byte_cnt = 0;
      rwds_o   <= 1'b0;
    end else if (ca_cnt < CA_BYTES) begin
      if (dq_oe_i) begin
        ca = {ca[CA_WIDTH-HBUS_DQ_WIDTH-1:0], dq_i};
        ca_cnt++;
        if (ca_cnt == CA_BYTES) begin
          cur_cmd.op  = ca[CA_RW_BIT] ? HBUS_OP_READ : HBUS_OP_WRITE;
          cur_cmd.adr = {ca[CA_BURST_BIT-1:CA_UPPER_LSB], ca[2:0]};
          last_cmd_o  = cur_cmd;
          // Linear burst set, reserved bits clear
          ca_ok_o     = ca[CA_BURST_BIT] && !ca[CA_RW_BIT-1] && (ca[CA_UPPER_LSB-1:3] == '0);
          txn_cnt_o++;
          lat_cnt     = LATENCY;
        end
      end
    end else if (lat_cnt > 0) begin
      lat_cnt--;
    end else if (cur_cmd.op == HBUS_OP_READ) begin
      if (byte_cnt < 2 * BURST_WORDS) begin
        rd_word = read_word(cur_cmd.adr + byte_cnt / 2);
        dq_o    <= (byte_cnt % 2 == 0) ? rd_word[15:8] : rd_word[7:0];
        rwds_o  <= 1'b1;
        byte_cnt++;
      end else begin
        rwds_o <= 1'b0;
      end
    end else if (dq_oe_i) begin
      // Upper byte of each word comes first
      if (byte_cnt % 2 == 0) begin
        wr_hi = dq_i;
      end else begin
        mem[cur_cmd.adr + byte_cnt / 2] = {wr_hi, dq_i};
      end
      byte_cnt++;
    end
  end

endmodule

// ==== hw/hyperbus_bridge.sv ====
/*
  HyperBus memory bridge top level
  User-side requests in, HyperBus pins out
*/

`timescale 1ns/1ns

module hyperbus_bridge #(
  parameter int FIFO_DATA_WIDTH = 32,
  parameter int FIFO_ASIZE      = 2,
  parameter int LATENCY         = 6
) (
  input  logic                                     clk,
  input  logic                                     hbus_clk,
  input  logic                                     hbus_rst,
  input  logic                                     rrq_i,
  input  logic                                     wrq_i,
  input  logic [hbus_cfg_pkg::HBUS_ADDR_WIDTH-1:0] adr_i,
  input  logic [FIFO_DATA_WIDTH-1:0]               tx_dat_i,
  output logic                                     cmd_ready_o,
  output logic [FIFO_DATA_WIDTH-1:0]               rx_dat_o,
  output logic                                     rx_valid_o,
  output logic                                     cs_n_o,
  output logic                                     ck_o,
  output logic [hbus_cfg_pkg::HBUS_DQ_WIDTH-1:0]   dq_o,
  output logic                                     dq_oe_o,
  output logic                                     rwds_o,
  input  logic [hbus_cfg_pkg::HBUS_DQ_WIDTH-1:0]   dq_i,
  input  logic                                     rwds_i
);

  hbus_native_if nat ();

  hyperbus_fifo #(
    .FIFO_DATA_WIDTH (FIFO_DATA_WIDTH),
    .FIFO_ASIZE      (FIFO_ASIZE)
  ) u_fifo (
    .clk         (clk),
    .hbus_clk    (hbus_clk),
    .hbus_rst    (hbus_rst),
    .rrq_i       (rrq_i),
    .wrq_i       (wrq_i),
    .adr_i       (adr_i),
    .tx_dat_i    (tx_dat_i),
    .cmd_ready_o (cmd_ready_o),
    .rx_dat_o    (rx_dat_o),
    .rx_valid_o  (rx_valid_o),
    .nat         (nat.ctrl)
  );

  hbus_phy #(
    .LATENCY (LATENCY)
  ) u_phy (
    .hbus_clk (hbus_clk),
    .hbus_rst (hbus_rst),
    .nat      (nat.phy),
    .cs_n_o   (cs_n_o),
    .ck_o     (ck_o),
    .dq_o     (dq_o),
    .dq_oe_o  (dq_oe_o),
    .rwds_o   (rwds_o),
    .dq_i     (dq_i),
    .rwds_i   (rwds_i)
  );

endmodule

// ==== hw/hbus_phy.sv ====
/*
  HyperBus PHY
  Sends the command-address, counts a fixed latency, then moves
  one byte per bus clock on the data pins
*/

`timescale 1ns/1ns

module hbus_phy #(
  parameter int LATENCY = 6
) (
  input  logic                                   hbus_clk,
  input  logic                                   hbus_rst,
  hbus_native_if.phy                             nat,
  output logic                                   cs_n_o,
  output logic                                   ck_o,
  output logic [hbus_cfg_pkg::HBUS_DQ_WIDTH-1:0] dq_o,
  output logic                                   dq_oe_o,
  output logic                                   rwds_o,
  input  logic [hbus_cfg_pkg::HBUS_DQ_WIDTH-1:0] dq_i,
  input  logic                                   rwds_i
);

  import hbus_cfg_pkg::*;

  localparam int CNT_MAX = (LATENCY > CA_BYTES) ? LATENCY : CA_BYTES;
  localparam int CNT_W   = $clog2(CNT_MAX + 1);

  typedef enum logic [2:0] {
    PHY_IDLE,
    PHY_CA,
    PHY_LAT,
    PHY_DATA,
    PHY_END
  } phy_state_e;

  phy_state_e phy_state;

  logic [CA_WIDTH-1:0]      ca_shift;
  logic [CA_WIDTH-1:0]      ca_word;
  logic [CNT_W-1:0]         cnt;
  logic                     is_read;
  logic                     byte_hi;
  logic [HBUS_DQ_WIDTH-1:0] hold_byte;

  // Linear burst, read flag and split address
  function automatic logic [CA_WIDTH-1:0] build_ca(
    input logic                       rd,
    input logic [HBUS_ADDR_WIDTH-1:0] adr
  );
    logic [CA_WIDTH-1:0] ca;
    ca                                    = '0;
    ca[CA_RW_BIT]                         = rd;
    ca[CA_BURST_BIT]                      = 1'b1;
    ca[CA_BURST_BIT-1:CA_UPPER_LSB]       = adr[31:3];
    ca[2:0]                               = adr[2:0];
    return ca;
  endfunction

  assign ca_word = build_ca(nat.rrq, nat.adr);

  always_ff @(posedge hbus_clk or posedge hbus_rst) begin
    if (hbus_rst) begin
      phy_state <= PHY_IDLE;
      cs_n_o    <= 1'b1;
      ck_o      <= 1'b0;
      dq_oe_o   <= 1'b0;
      nat.busy  <= 1'b0;
      nat.ready <= 1'b0;
      nat.valid <= 1'b0;
      cnt       <= '0;
      is_read   <= 1'b0;
      byte_hi   <= 1'b0;
    end else begin
      nat.ready <= 1'b0;
      nat.valid <= 1'b0;
      ck_o      <= cs_n_o ? 1'b0 : ~ck_o;
      case (phy_state)
        PHY_IDLE: begin
          if (nat.rrq || nat.wrq) begin
            nat.busy  <= 1'b1;
            cs_n_o    <= 1'b0;
            dq_oe_o   <= 1'b1;
            is_read   <= nat.rrq;
            cnt       <= CNT_W'(CA_BYTES - 1);
            phy_state <= PHY_CA;
          end else begin
            nat.busy <= 1'b0;
          end
        end
        PHY_CA: begin
          if (cnt == '0) begin
            dq_oe_o   <= 1'b0;
            cnt       <= CNT_W'(LATENCY - 1);
            phy_state <= PHY_LAT;
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        PHY_LAT: begin
          if (cnt == '0) begin
            phy_state <= PHY_DATA;
            byte_hi   <= 1'b0;
            if (!is_read) begin
              // Take the first word together with its upper byte
              dq_oe_o   <= 1'b1;
              nat.ready <= 1'b1;
              byte_hi   <= 1'b1;
            end
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        PHY_DATA: begin
          if (!is_read) begin
            if (byte_hi) begin
              byte_hi <= 1'b0;
            end else if (nat.wrq) begin
              nat.ready <= 1'b1;
              byte_hi   <= 1'b1;
            end else begin
              dq_oe_o   <= 1'b0;
              phy_state <= PHY_END;
            end
          end else if (!nat.rrq) begin
            phy_state <= PHY_END;
          end else if (rwds_i) begin
            byte_hi <= ~byte_hi;
            if (byte_hi) begin
              nat.valid <= 1'b1;
            end
          end
        end
        PHY_END: begin
          cs_n_o    <= 1'b1;
          ck_o      <= 1'b0;
          phy_state <= PHY_IDLE;
        end
        default: phy_state <= PHY_IDLE;
      endcase
    end
  end

  // Pin byte and read word datapath
  always_ff @(posedge hbus_clk) begin
    case (phy_state)
      PHY_IDLE: begin
        if (nat.rrq || nat.wrq) begin
          ca_shift <= ca_word << HBUS_DQ_WIDTH;
          dq_o     <= ca_word[CA_WIDTH-1 -: HBUS_DQ_WIDTH];
        end
      end
      PHY_CA: begin
        dq_o     <= ca_shift[CA_WIDTH-1 -: HBUS_DQ_WIDTH];
        ca_shift <= ca_shift << HBUS_DQ_WIDTH;
      end
      PHY_LAT, PHY_DATA: begin
        if (!is_read && !byte_hi) begin
          {dq_o, hold_byte} <= nat.wdat;
        end else if (!is_read) begin
          dq_o <= hold_byte;
        end else if (rwds_i && !byte_hi) begin
          hold_byte <= dq_i;
        end else if (rwds_i) begin
          nat.rdat <= {hold_byte, dq_i};
        end
      end
      default: ;
    endcase
  end

  // Strobe stays low on writes since bytes are never masked
  assign rwds_o = 1'b0;

  a_oe_inside_cs : assert property (
    @(posedge hbus_clk) disable iff (hbus_rst) cs_n_o |-> !dq_oe_o
  );

endmodule

// ==== hw/hyperbus_fifo.sv ====
/*
  HyperBus request FIFO and sequencer
  Captures user reads and writes, carries them across clock domains
  and splits or joins data words on the native bus
*/

`timescale 1ns/1ns

module hyperbus_fifo #(
  parameter int FIFO_DATA_WIDTH = 32,
  parameter int FIFO_ASIZE      = 2
) (
  input  logic                                     clk,
  input  logic                                     hbus_clk,
  input  logic                                     hbus_rst,
  input  logic                                     rrq_i,
  input  logic                                     wrq_i,
  input  logic [hbus_cfg_pkg::HBUS_ADDR_WIDTH-1:0] adr_i,
  input  logic [FIFO_DATA_WIDTH-1:0]               tx_dat_i,
  output logic                                     cmd_ready_o,
  output logic [FIFO_DATA_WIDTH-1:0]               rx_dat_o,
  output logic                                     rx_valid_o,
  hbus_native_if.ctrl                              nat
);

  import hbus_cfg_pkg::*;
  import hbus_cmd_pkg::*;

  // Native words per user word
  localparam int WORDS = FIFO_DATA_WIDTH / HBUS_DATA_WIDTH;
  localparam int CNT_W = $clog2(WORDS + 1);

  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_READ,
    SEQ_WRITE
  } seq_state_e;

  seq_state_e seq_state;

  hbus_cmd_t cmd_wdata, cmd_rdata;
  logic      cmd_winc, cmd_rinc, cmd_full, cmd_empty;

  logic [FIFO_DATA_WIDTH-1:0] tx_rdata;
  logic                       tx_winc, tx_rinc, tx_full, tx_empty;

  logic [FIFO_DATA_WIDTH-1:0] rx_rdata;
  logic                       rx_winc, rx_rinc, rx_full, rx_empty;

  logic [FIFO_DATA_WIDTH-1:0] tx_shift, rx_shift;
  logic [CNT_W-1:0]           word_cnt;
  logic                       rst_done;

  async_fifo #(.DSIZE($bits(hbus_cmd_t)), .ASIZE(FIFO_ASIZE)) u_cmd_fifo (
    .wclk_i   (clk),
    .winc_i   (cmd_winc),
    .wdata_i  (cmd_wdata),
    .wfull_o  (cmd_full),
    .rclk_i   (hbus_clk),
    .rinc_i   (cmd_rinc),
    .rdata_o  (cmd_rdata),
    .rempty_o (cmd_empty),
    .hbus_rst (hbus_rst)
  );

  async_fifo #(.DSIZE(FIFO_DATA_WIDTH), .ASIZE(FIFO_ASIZE)) u_tx_fifo (
    .wclk_i   (clk),
    .winc_i   (tx_winc),
    .wdata_i  (tx_dat_i),
    .wfull_o  (tx_full),
    .rclk_i   (hbus_clk),
    .rinc_i   (tx_rinc),
    .rdata_o  (tx_rdata),
    .rempty_o (tx_empty),
    .hbus_rst (hbus_rst)
  );

  async_fifo #(.DSIZE(FIFO_DATA_WIDTH), .ASIZE(FIFO_ASIZE)) u_rx_fifo (
    .wclk_i   (hbus_clk),
    .winc_i   (rx_winc),
    .wdata_i  (rx_shift),
    .wfull_o  (rx_full),
    .rclk_i   (clk),
    .rinc_i   (rx_rinc),
    .rdata_o  (rx_rdata),
    .rempty_o (rx_empty),
    .hbus_rst (hbus_rst)
  );

  // User side, strobes push straight into the FIFOs
  assign cmd_winc      = rrq_i | wrq_i;
  assign cmd_wdata.op  = rrq_i ? HBUS_OP_READ : HBUS_OP_WRITE;
  assign cmd_wdata.adr = adr_i;
  assign tx_winc       = wrq_i;
  assign rx_rinc       = ~rx_empty;
  assign cmd_ready_o   = rst_done & ~cmd_full & ~tx_full;

  always_ff @(posedge clk or posedge hbus_rst) begin
    if (hbus_rst) begin
      rst_done   <= 1'b0;
      rx_valid_o <= 1'b0;
    end else begin
      rst_done   <= 1'b1;
      rx_valid_o <= ~rx_empty;
    end
  end

  always_ff @(posedge clk) begin
    if (!rx_empty) begin
      rx_dat_o <= rx_rdata;
    end
  end

  // Bus-domain sequencer, one command at a time
  always_ff @(posedge hbus_clk or posedge hbus_rst) begin
    if (hbus_rst) begin
      seq_state <= SEQ_IDLE;
      nat.rrq   <= 1'b0;
      nat.wrq   <= 1'b0;
      cmd_rinc  <= 1'b0;
      tx_rinc   <= 1'b0;
      rx_winc   <= 1'b0;
      word_cnt  <= '0;
    end else begin
      cmd_rinc <= 1'b0;
      tx_rinc  <= 1'b0;
      rx_winc  <= 1'b0;
      case (seq_state)
        SEQ_IDLE: begin
          if (!cmd_empty && !nat.busy) begin
            if (cmd_rdata.op == HBUS_OP_READ && !rx_full) begin
              nat.rrq   <= 1'b1;
              cmd_rinc  <= 1'b1;
              word_cnt  <= CNT_W'(WORDS);
              seq_state <= SEQ_READ;
            end else if (cmd_rdata.op == HBUS_OP_WRITE && !tx_empty) begin
              nat.wrq   <= 1'b1;
              cmd_rinc  <= 1'b1;
              word_cnt  <= CNT_W'(WORDS);
              seq_state <= SEQ_WRITE;
            end
          end
        end
        SEQ_READ: begin
          if (nat.valid) begin
            word_cnt <= word_cnt - 1'b1;
            if (word_cnt == CNT_W'(1)) begin
              nat.rrq   <= 1'b0;
              rx_winc   <= 1'b1;
              seq_state <= SEQ_IDLE;
            end
          end
        end
        SEQ_WRITE: begin
          if (nat.ready) begin
            word_cnt <= word_cnt - 1'b1;
            if (word_cnt == CNT_W'(1)) begin
              nat.wrq   <= 1'b0;
              tx_rinc   <= 1'b1;
              seq_state <= SEQ_IDLE;
            end
          end
        end
        default: seq_state <= SEQ_IDLE;
      endcase
    end
  end

  // Address and data shift registers
  always_ff @(posedge hbus_clk) begin
    if (seq_state == SEQ_IDLE && !cmd_empty && !nat.busy) begin
      nat.adr  <= cmd_rdata.adr;
      tx_shift <= tx_rdata;
    end else if (seq_state == SEQ_WRITE && nat.ready) begin
      tx_shift <= tx_shift << HBUS_DATA_WIDTH;
    end
    if (seq_state == SEQ_READ && nat.valid) begin
      rx_shift <= (rx_shift << HBUS_DATA_WIDTH) | FIFO_DATA_WIDTH'(nat.rdat);
    end
  end

  // Upper word goes first
  assign nat.wdat = tx_shift[FIFO_DATA_WIDTH-1 -: HBUS_DATA_WIDTH];

  a_one_request : assert property (
    @(posedge hbus_clk) disable iff (hbus_rst) !(nat.rrq && nat.wrq)
  );

endmodule

// ==== hw/async_fifo.sv ====
/*
  Dual-clock FIFO
  First-word-fall-through, Gray-coded pointers crossing through
  two-flop synchronizers in each direction
*/

`timescale 1ns/1ns

module async_fifo #(
  parameter int DSIZE = 32,
  parameter int ASIZE = 2
) (
  input  logic             wclk_i,
  input  logic             winc_i,
  input  logic [DSIZE-1:0] wdata_i,
  output logic             wfull_o,
  input  logic             rclk_i,
  input  logic             rinc_i,
  output logic [DSIZE-1:0] rdata_o,
  output logic             rempty_o,
  input  logic             hbus_rst
);

  localparam int DEPTH = 1 << ASIZE;

  logic [DSIZE-1:0] mem [DEPTH];

  logic [ASIZE:0] wbin, wgray, wbin_next, wgray_next;
  logic [ASIZE:0] rbin, rgray, rbin_next, rgray_next;
  logic [ASIZE:0] wq1_rgray, wq2_rgray;
  logic [ASIZE:0] rq1_wgray, rq2_wgray;

  // Write side
  assign wbin_next  = wbin + {{ASIZE{1'b0}}, (winc_i & ~wfull_o)};
  assign wgray_next = (wbin_next >> 1) ^ wbin_next;

  always_ff @(posedge wclk_i or posedge hbus_rst) begin
    if (hbus_rst) begin
      wbin      <= '0;
      wgray     <= '0;
      wq1_rgray <= '0;
      wq2_rgray <= '0;
      wfull_o   <= 1'b0;
    end else begin
      wbin      <= wbin_next;
      wgray     <= wgray_next;
      wq1_rgray <= rgray;
      wq2_rgray <= wq1_rgray;
      // Full when the top two Gray bits differ and the rest match
      wfull_o   <= (wgray_next == {~wq2_rgray[ASIZE:ASIZE-1], wq2_rgray[ASIZE-2:0]});
    end
  end

  always_ff @(posedge wclk_i) begin
    if (winc_i && !wfull_o) begin
      mem[wbin[ASIZE-1:0]] <= wdata_i;
    end
  end

  // Read side
  assign rbin_next  = rbin + {{ASIZE{1'b0}}, (rinc_i & ~rempty_o)};
  assign rgray_next = (rbin_next >> 1) ^ rbin_next;

  always_ff @(posedge rclk_i or posedge hbus_rst) begin
    if (hbus_rst) begin
      rbin      <= '0;
      rgray     <= '0;
      rq1_wgray <= '0;
      rq2_wgray <= '0;
      rempty_o  <= 1'b1;
    end else begin
      rbin      <= rbin_next;
      rgray     <= rgray_next;
      rq1_wgray <= wgray;
      rq2_wgray <= rq1_wgray;
      rempty_o  <= (rgray_next == rq2_wgray);
    end
  end

  // Head of the queue is visible without a pop
  assign rdata_o = mem[rbin[ASIZE-1:0]];

  a_no_overflow : assert property (
    @(posedge wclk_i) disable iff (hbus_rst) winc_i |-> !wfull_o
  );

  a_no_underflow : assert property (
    @(posedge rclk_i) disable iff (hbus_rst) rinc_i |-> !rempty_o
  );

endmodule

// ==== hw/hbus_native_if.sv ====
/*
  HyperBus native interface
  Word-level request and data bus between the sequencer and the PHY
*/

`timescale 1ns/1ns

interface hbus_native_if;

  logic [hbus_cfg_pkg::HBUS_ADDR_WIDTH-1:0] adr;
  logic [hbus_cfg_pkg::HBUS_DATA_WIDTH-1:0] wdat;
  logic [hbus_cfg_pkg::HBUS_DATA_WIDTH-1:0] rdat;
  logic                                     rrq;
  logic                                     wrq;
  // One-cycle strobes from the PHY
  logic                                     ready;
  logic                                     valid;
  logic                                     busy;

  modport ctrl (
    output adr, wdat, rrq, wrq,
    input  rdat, ready, valid, busy
  );

  modport phy (
    input  adr, wdat, rrq, wrq,
    output rdat, ready, valid, busy
  );

endinterface

// ==== hw/hbus_cmd_pkg.sv ====
/*
  HyperBus command definitions
  Opcode encoding and the command word passed through the command FIFO
*/

package hbus_cmd_pkg;

  typedef enum logic {
    HBUS_OP_WRITE = 1'b0,
    HBUS_OP_READ  = 1'b1
  } hbus_op_e;

  // Opcode on top, word address below, 33 bits in total
  typedef struct packed {
    hbus_op_e                                op;
    logic [hbus_cfg_pkg::HBUS_ADDR_WIDTH-1:0] adr;
  } hbus_cmd_t;

endpackage

// ==== hw/hbus_cfg_pkg.sv ====
/*
  HyperBus configuration constants
  Fixed bus widths and the layout of the 48-bit command-address
*/

package hbus_cfg_pkg;

  // Native word-level bus
  localparam int HBUS_ADDR_WIDTH = 32;
  localparam int HBUS_DATA_WIDTH = 16;

  // Pin level byte lane
  localparam int HBUS_DQ_WIDTH = 8;

  // Command-address phase
  localparam int CA_BYTES = 6;
  localparam int CA_WIDTH = CA_BYTES * HBUS_DQ_WIDTH;

  // Read flag and linear burst flag positions
  localparam int CA_RW_BIT    = 47;
  localparam int CA_BURST_BIT = 45;

  // Address bits 31..3 land on 44..16, bits 2..0 on 2..0
  localparam int CA_UPPER_LSB = 16;

endpackage
